// ==== alu_datapath.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/alu_if.sv
logic/alu_inputs.sv
logic/alu_module.sv
logic/alu_result_regs.sv
logic/register_file.sv
logic/alu_datapath.sv
test/alu_datapath_tb.sv

// ==== Bender.yml ====
package:
  name: alu_datapath

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/alu_if.sv
      - logic/alu_inputs.sv
      - logic/alu_module.sv
      - logic/alu_result_regs.sv
      - logic/register_file.sv
      - logic/alu_datapath.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/alu_datapath_tb.sv

// ==== test/alu_datapath_tb.sv ====
`include "cpu_macros.svh"

module alu_datapath_tb;

    localparam int TEST_CYCLES = 8 + 4 + 48 + 48 + 10 * 3 + 64 + 3;
    localparam int TIMEOUT     = TEST_CYCLES * 20 + 400;

    logic                         clk = 1'b0;
    logic                         rst = 1'b1;
    cpu_pkg::instr_ctrl_signals_t instr_vec = '0;
    cpu_pkg::ucode_ctrl_signals_t ucode_vec = '0;
    logic [7:0]                   r_data = '0;
    logic [15:0]                  pc = '0;
    logic [7:0]                   a, x, y, sp, alu_out;
    logic                         c_out;
    cpu_pkg::status_t             status;

    // expected state mirroring the architectural registers
    logic [7:0]       exp_a, exp_x, exp_y, exp_sp, exp_alu_out;
    logic             exp_c_out;
    cpu_pkg::status_t exp_status;

    logic        hold_step = 1'b0;
    logic        wide_start = 1'b0;
    logic [15:0] wide_sum = '0;
    logic [31:0] lfsr_state = 32'haf29a107;
    int          value_errors = 0;
    int          seq_errors = 0;
    int          checks = 0;

    alu_datapath i_dut (
        .clk (clk), .rst (rst), .instr_ctrl_vector (instr_vec), .ucode_vector (ucode_vec),
        .r_data (r_data), .pc (pc), .a (a), .x (x), .y (y), .sp (sp),
        .alu_out (alu_out), .c_out (c_out), .status (status)
    );

    always #10 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic cpu_pkg::instr_ctrl_signals_t instr_fields(
        input logic [2:0] op, input logic [2:0] s1, input logic s2, input logic inv,
        input logic [1:0] cs, input logic [2:0] dest, input logic we
    );
        cpu_pkg::instr_ctrl_signals_t v;
        v.alu_op       = cpu_pkg::ctrl_alu_op_t'(op);
        v.alu_src1     = cpu_pkg::alu_src1_t'(s1);
        v.alu_src2     = cpu_pkg::alu_src2_t'(s2);
        v.alu_src2_inv = inv;
        v.alu_c_src    = cpu_pkg::alu_c_src_t'(cs);
        v.alu_dest     = cpu_pkg::reg_dest_t'(dest);
        v.alu_flags_we = we;
        return v;
    endfunction

    function automatic cpu_pkg::ucode_ctrl_signals_t ucode_fields(
        input logic [2:0] op, input logic [2:0] s1, input logic s2, input logic inv,
        input logic [1:0] cs, input logic ictrl
    );
        cpu_pkg::ucode_ctrl_signals_t v;
        v.alu_op       = cpu_pkg::ctrl_alu_op_t'(op);
        v.alu_src1     = cpu_pkg::alu_src1_t'(s1);
        v.alu_src2     = cpu_pkg::alu_src2_t'(s2);
        v.alu_src2_inv = inv;
        v.alu_c_src    = cpu_pkg::alu_c_src_t'(cs);
        v.instr_ctrl   = cpu_pkg::instr_ctrl_t'(ictrl);
        return v;
    endfunction

    // microcode step that hands the alu to the instruction
    function automatic cpu_pkg::ucode_ctrl_signals_t instr_turn();
        return ucode_fields(3'd0, 3'd0, 1'b0, 1'b0, 2'd1, 1'b1);
    endfunction

    // any legal instruction vector with sources unchecked against the path
    function automatic cpu_pkg::instr_ctrl_signals_t random_instr();
        logic [2:0] op;
        logic [2:0] d;
        op = random_bits(3) % 7;
        d = random_bits(3) % 5;
        return instr_fields(op, random_bits(3), random_bits(1), random_bits(1),
                            random_bits(2), d, random_bits(1));
    endfunction

    // {v, c, result} as the ALU rules define them
    function automatic logic [9:0] expected_alu(input logic [2:0] op, input logic [7:0] s1,
                                                input logic [7:0] s2, input logic inv,
                                                input logic cin);
        logic [7:0] b;
        logic [8:0] sum;
        b = inv ? ~s2 : s2;
        sum = {1'b0, s1} + {1'b0, b} + {8'h00, cin};
        case (op)
            3'd1: return {(s1[7] == b[7]) && (sum[7] != s1[7]), sum};
            3'd2: return {2'b00, s1 & s2};
            3'd3: return {2'b00, s1 | s2};
            3'd4: return {2'b00, s1 ^ s2};
            3'd5: return {1'b0, s1[7], s1[6:0], cin};
            3'd6: return {1'b0, s1[0], cin, s1[7:1]};
            default: return 10'h000;
        endcase
    endfunction

    always @(posedge clk) begin : ref_model
        logic [2:0] op;
        logic [7:0] s1, s2;
        logic       inv, cin, we;
        logic [2:0] dest;
        logic [9:0] r;
        op = 3'd0;
        s1 = '0;
        s2 = '0;
        inv = 1'b0;
        cin = 1'b0;
        dest = 3'd0;
        we = 1'b0;
        if (ucode_vec.alu_op == cpu_pkg::ALUOP_ADD) begin
            op = 3'd1;
            inv = ucode_vec.alu_src2_inv;
            s2 = ucode_vec.alu_src2 == cpu_pkg::SRC2_RMEM ? r_data : 8'h00;
            case (ucode_vec.alu_src1)
                cpu_pkg::SRC1_X:      s1 = exp_x;
                cpu_pkg::SRC1_Y:      s1 = exp_y;
                cpu_pkg::SRC1_RMEM:   s1 = r_data;
                cpu_pkg::SRC1_SP:     s1 = exp_sp;
                cpu_pkg::SRC1_PCHI:   s1 = pc[15:8];
                cpu_pkg::SRC1_PCLO:   s1 = pc[7:0];
                cpu_pkg::SRC1_ALUOUT: s1 = exp_alu_out;
                default:              s1 = 8'h00;
            endcase
            cin = ucode_vec.alu_c_src == cpu_pkg::ALUC_1 ||
                  (ucode_vec.alu_c_src == cpu_pkg::ALUC_ALUCOUT && exp_c_out);
        end else if (ucode_vec.alu_op == cpu_pkg::ALUOP_HOLD &&
                     ucode_vec.instr_ctrl == cpu_pkg::INSTR_CTRL_1) begin
            op = instr_vec.alu_op;
            inv = instr_vec.alu_src2_inv;
            s2 = instr_vec.alu_src2 == cpu_pkg::SRC2_RMEM ? r_data : 8'h00;
            case (instr_vec.alu_src1)
                cpu_pkg::SRC1_A:    s1 = exp_a;
                cpu_pkg::SRC1_X:    s1 = exp_x;
                cpu_pkg::SRC1_Y:    s1 = exp_y;
                cpu_pkg::SRC1_RMEM: s1 = r_data;
                cpu_pkg::SRC1_SP:   s1 = exp_sp;
                default:            s1 = 8'h00;
            endcase
            cin = instr_vec.alu_c_src == cpu_pkg::ALUC_1 ||
                  (instr_vec.alu_c_src == cpu_pkg::ALUC_C && exp_status.c);
            // a held instruction has nothing to write back
            dest = op != 3'd0 ? instr_vec.alu_dest : 3'd0;
            we = op != 3'd0 && instr_vec.alu_flags_we;
        end
        r = expected_alu(op, s1, s2, inv, cin);
        if (rst) begin
            exp_a <= '0;
            exp_x <= '0;
            exp_y <= '0;
            exp_sp <= `CPU_SP_RESET;
            exp_alu_out <= '0;
            exp_c_out <= 1'b0;
            exp_status <= '0;
        end else begin
            if (op != 3'd0) begin
                exp_alu_out <= r[7:0];
                exp_c_out <= r[8];
            end
            if (we) begin
                exp_status.n <= r[7];
                exp_status.z <= r[7:0] == 8'h00;
                exp_status.c <= r[8];
                if (op == 3'd1) exp_status.v <= r[9];
            end
            case (dest)
                3'd1: exp_a <= r[7:0];
                3'd2: exp_x <= r[7:0];
                3'd3: exp_y <= r[7:0];
                3'd4: exp_sp <= r[7:0];
                default: ;
            endcase
        end
    end

    task automatic report_value(input string what, input logic [7:0] got,
                                input logic [7:0] want);
        value_errors++;
        $display("Error at time %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    chk_a: assert property (@(posedge clk) disable iff (rst) a == exp_a) checks++;
        else report_value("A", $sampled(a), $sampled(exp_a));
    chk_x: assert property (@(posedge clk) disable iff (rst) x == exp_x) checks++;
        else report_value("X", $sampled(x), $sampled(exp_x));
    chk_y: assert property (@(posedge clk) disable iff (rst) y == exp_y) checks++;
        else report_value("Y", $sampled(y), $sampled(exp_y));
    chk_sp: assert property (@(posedge clk) disable iff (rst) sp == exp_sp) checks++;
        else report_value("SP", $sampled(sp), $sampled(exp_sp));
    chk_out: assert property (@(posedge clk) disable iff (rst) alu_out == exp_alu_out) checks++;
        else report_value("alu_out", $sampled(alu_out), $sampled(exp_alu_out));
    chk_cout: assert property (@(posedge clk) disable iff (rst) c_out == exp_c_out) checks++;
        else report_value("c_out", $sampled(c_out), $sampled(exp_c_out));
    chk_flags: assert property (@(posedge clk) disable iff (rst) status == exp_status) checks++;
        else report_value("status NVZC", $sampled(status), $sampled(exp_status));

    // low byte then high byte of pc plus offset
    chk_wide: assert property (@(posedge clk) disable iff (rst)
        wide_start |=> (alu_out == wide_sum[7:0]) ##1 (alu_out == wide_sum[15:8]))
        else begin
            seq_errors++;
            $display("Error at time %0t: 16-bit sum %h not seen in alu_out", $time,
                     $sampled(wide_sum));
        end

    chk_hold: assert property (@(posedge clk) disable iff (rst)
        hold_step |=> $stable({a, x, y, sp, alu_out, c_out, status}))
        else begin
            seq_errors++;
            $display("Error at time %0t: an output changed after a held step", $time);
        end

    task automatic issue(input cpu_pkg::instr_ctrl_signals_t iv,
                         input cpu_pkg::ucode_ctrl_signals_t uv,
                         input logic [7:0] rd, input logic [15:0] p);
        @(posedge clk);
        instr_vec <= iv;
        ucode_vec <= uv;
        r_data <= rd;
        pc <= p;
        hold_step <= 1'b0;
        wide_start <= 1'b0;
    endtask

    task automatic arith_and_logic(input int n, input logic logic_ops);
        logic [2:0] op;
        logic [1:0] cs;
        for (int i = 0; i < n; i++) begin
            op = logic_ops ? 3'd2 + random_bits(3) % 5 : 3'd1;
            cs = random_bits(2);
            if (cs == 2'd3) cs = 2'd0;
            issue(instr_fields(op, random_bits(3) % 5, logic_ops & random_bits(1),
                               random_bits(1), cs, logic_ops ? random_bits(3) % 5 :
                               1 + random_bits(2) % 3, !logic_ops | random_bits(1)),
                  instr_turn(), random_bits(8), 16'h0000);
        end
    endtask

    task automatic wide_adds(input int n);
        logic [15:0] p;
        logic [7:0]  off;
        for (int i = 0; i < n; i++) begin
            p = random_bits(16);
            off = random_bits(8);
            issue(random_instr(), ucode_fields(3'd1, 3'd6, 1'b0, 1'b0, 2'd1, 1'b1), off, p);
            wide_start <= 1'b1;
            wide_sum <= p + {8'h00, off};
            issue(random_instr(), ucode_fields(3'd1, 3'd5, 1'b1, 1'b0, 2'd3, 1'b0),
                  random_bits(8), p);
            issue(random_instr(), ucode_fields(3'd1, 3'd7, 1'b0, random_bits(1), 2'd2, 1'b1),
                  random_bits(8), p);
        end
    endtask

    task automatic holds_and_mix(input int n);
        logic [1:0] kind;
        for (int i = 0; i < n; i++) begin
            kind = random_bits(2);
            case (kind)
                2'd0: issue(random_instr(), ucode_fields(3'd0, random_bits(3), random_bits(1),
                            random_bits(1), random_bits(2), 1'b0), random_bits(8), 16'hffff);
                2'd1: issue(instr_fields(3'd0, random_bits(3), random_bits(1), random_bits(1),
                            random_bits(2), 3'd1, 1'b1), instr_turn(), random_bits(8), 16'h0);
                2'd2: issue(random_instr(), ucode_fields(3'd2 + random_bits(3) % 5, 3'd3,
                            1'b0, 1'b0, 2'd2, 1'b1), random_bits(8), 16'h1234);
                default: issue(random_instr(), random_bits(1) ? instr_turn() :
                               ucode_fields(3'd1, 3'd0, 1'b0, 1'b0, 2'd0, 1'b0),
                               random_bits(8), random_bits(16));
            endcase
            if (kind != 2'd3) hold_step <= 1'b1;
        end
    endtask

    initial begin
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // load every register from the read-data bus
        for (int d = 1; d <= 4; d++) begin
            issue(instr_fields(3'd1, 3'd3, 1'b1, 1'b0, 2'd1, d, 1'b1), instr_turn(),
                  random_bits(8), 16'h0000);
        end
        arith_and_logic(48, 1'b0);
        arith_and_logic(48, 1'b1);
        wide_adds(10);
        holds_and_mix(64);
        repeat (3) issue('0, '0, 8'h00, 16'h0000);
        @(negedge clk);
        $display("Summary: %0d value errors, %0d sequence errors, %0d value checks passed",
                 value_errors, seq_errors, checks);
        if (value_errors == 0 && seq_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the test sequence did not finish in %0d time units", TIMEOUT);
        $display("Errors found");
        $finish;
    end

endmodule : alu_datapath_tb

// ==== logic/alu_datapath.sv ====
`include "cpu_macros.svh"

module alu_datapath (
    input  logic                         clk,
    input  logic                         rst,
    input  cpu_pkg::instr_ctrl_signals_t instr_ctrl_vector,
    input  cpu_pkg::ucode_ctrl_signals_t ucode_vector,
    input  logic [`CPU_DATA_W-1:0]       r_data,
    input  logic [`CPU_ADDR_W-1:0]       pc,
    output logic [`CPU_DATA_W-1:0]       a,
    output logic [`CPU_DATA_W-1:0]       x,
    output logic [`CPU_DATA_W-1:0]       y,
    output logic [`CPU_DATA_W-1:0]       sp,
    output logic [`CPU_DATA_W-1:0]       alu_out,
    output logic                         c_out,
    output cpu_pkg::status_t             status
);

    alu_if alu_bus ();

    // operand selection feeds on the registered results and the C flag
    alu_inputs i_alu_inputs (
        .instr_ctrl_vector (instr_ctrl_vector),
        .ucode_vector      (ucode_vector),
        .a                 (a),
        .x                 (x),
        .y                 (y),
        .sp                (sp),
        .r_data            (r_data),
        .alu_out           (alu_out),
        .pc                (pc),
        .c_out             (c_out),
        .c_flag            (status.c),
        .alu               (alu_bus.select)
    );

    alu_module i_alu_module (
        .alu (alu_bus.compute)
    );

    // results and flags, one cycle after the vectors
    alu_result_regs i_alu_result_regs (
        .clk     (clk),
        .rst     (rst),
        .alu     (alu_bus.commit),
        .alu_out (alu_out),
        .c_out   (c_out),
        .status  (status)
    );

    register_file i_register_file (
        .clk (clk),
        .rst (rst),
        .alu (alu_bus.commit),
        .a   (a),
        .x   (x),
        .y   (y),
        .sp  (sp)
    );

endmodule : alu_datapath

// ==== logic/register_file.sv ====
`include "cpu_macros.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst,
    alu_if.commit                  alu,
    output logic [`CPU_DATA_W-1:0] a,
    output logic [`CPU_DATA_W-1:0] x,
    output logic [`CPU_DATA_W-1:0] y,
    output logic [`CPU_DATA_W-1:0] sp
);

    // one destination per cycle picked by dest
    always_ff @(posedge clk) begin
        if (rst) begin
            a  <= '0;
            x  <= '0;
            y  <= '0;
            sp <= `CPU_SP_RESET;
        end else begin
            case (alu.dest)
                cpu_pkg::DEST_A:  a  <= alu.out;
                cpu_pkg::DEST_X:  x  <= alu.out;
                cpu_pkg::DEST_Y:  y  <= alu.out;
                cpu_pkg::DEST_SP: sp <= alu.out;
                default: begin
                    // nothing written for DEST_NONE
                end
            endcase
        end
    end

    a_single_write: assert property (
        @(posedge clk) disable iff (rst)
        $countones({$changed(a), $changed(x), $changed(y), $changed(sp)}) <= 1
    ) else $error("more than one register changed in a cycle");

endmodule : register_file

// ==== logic/alu_result_regs.sv ====
`include "cpu_macros.svh"

module alu_result_regs (
    input  logic                   clk,
    input  logic                   rst,
    alu_if.commit                  alu,
    output logic [`CPU_DATA_W-1:0] alu_out,
    output logic                   c_out,
    output cpu_pkg::status_t       status
);

    // result and carry kept for multi-byte chaining
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_out <= '0;
            c_out   <= 1'b0;
        end else if (alu.op != cpu_pkg::ALUOP_HOLD) begin
            alu_out <= alu.out;
            c_out   <= alu.c_out;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
        end else if (alu.flags_we) begin
            status.n <= alu.n_out;
            status.z <= alu.z_out;
            status.c <= alu.c_out;
            // V only has meaning for add
            if (alu.op == cpu_pkg::ALUOP_ADD) begin
                status.v <= alu.v_out;
            end
        end
    end

    // flags only move on a cycle that enabled the write
    a_status_hold: assert property (
        @(posedge clk) disable iff (rst)
        !alu.flags_we |=> $stable(status)
    ) else $error("status changed without flags_we");

endmodule : alu_result_regs

// ==== logic/alu_module.sv ====
`include "cpu_macros.svh"

module alu_module (
    alu_if.compute alu
);

    localparam int W = `CPU_DATA_W;

    logic [W-1:0] add_src2;
    // low bits summed separately, the top bit holds the carry into the msb
    logic [W-1:0] low_sum;
    logic [W:0]   full_sum;

    logic [W-1:0] add_res;
    logic [W-1:0] and_res;
    logic [W-1:0] or_res;
    logic [W-1:0] xor_res;
    logic [W-1:0] rol_res;
    logic [W-1:0] ror_res;
    logic         add_c;
    logic         rol_c;
    logic         ror_c;

    // subtract is add with inverted src2 and carry-in 1
    assign add_src2 = alu.src2_inv ? ~alu.src2 : alu.src2;
    assign low_sum  = {1'b0, alu.src1[W-2:0]} + {1'b0, add_src2[W-2:0]} +
                      {{(W-1){1'b0}}, alu.c_in};
    assign full_sum = {1'b0, low_sum} +
                      {1'b0, alu.src1[W-1], {(W-1){1'b0}}} +
                      {1'b0, add_src2[W-1], {(W-1){1'b0}}};

    assign add_res = full_sum[W-1:0];
    assign add_c   = full_sum[W];
    // signed overflow when carry into and out of the msb differ
    assign alu.v_out = add_c ^ low_sum[W-1];

    assign and_res = alu.src1 & alu.src2;
    assign or_res  = alu.src1 | alu.src2;
    assign xor_res = alu.src1 ^ alu.src2;

    // rotates go through the carry
    assign rol_res = {alu.src1[W-2:0], alu.c_in};
    assign rol_c   = alu.src1[W-1];
    assign ror_res = {alu.c_in, alu.src1[W-1:1]};
    assign ror_c   = alu.src1[0];

    always_comb begin
        alu.out   = '0;
        alu.c_out = 1'b0;
        case (alu.op)
            cpu_pkg::ALUOP_ADD: begin
                alu.out   = add_res;
                alu.c_out = add_c;
            end
            cpu_pkg::ALUOP_AND: alu.out = and_res;
            cpu_pkg::ALUOP_OR:  alu.out = or_res;
            cpu_pkg::ALUOP_XOR: alu.out = xor_res;
            cpu_pkg::ALUOP_SHIFT_LEFT: begin
                alu.out   = rol_res;
                alu.c_out = rol_c;
            end
            cpu_pkg::ALUOP_SHIFT_RIGHT: begin
                alu.out   = ror_res;
                alu.c_out = ror_c;
            end
            default: alu.out = '0;
        endcase
    end

    assign alu.z_out = alu.out == '0;
    assign alu.n_out = alu.out[W-1];

    // logic ops must not leak a carry into the flag stage
    always_comb begin
        if (alu.op inside {cpu_pkg::ALUOP_AND, cpu_pkg::ALUOP_OR, cpu_pkg::ALUOP_XOR}) begin
            a_logic_no_carry: assert final (alu.c_out == 1'b0)
                else $error("logic operation produced a carry");
        end
    end

endmodule : alu_module

// ==== logic/alu_inputs.sv ====
`include "cpu_macros.svh"

module alu_inputs (
    input  cpu_pkg::instr_ctrl_signals_t instr_ctrl_vector,
    input  cpu_pkg::ucode_ctrl_signals_t ucode_vector,
    input  logic [`CPU_DATA_W-1:0]       a,
    input  logic [`CPU_DATA_W-1:0]       x,
    input  logic [`CPU_DATA_W-1:0]       y,
    input  logic [`CPU_DATA_W-1:0]       sp,
    input  logic [`CPU_DATA_W-1:0]       r_data,
    input  logic [`CPU_DATA_W-1:0]       alu_out,
    input  logic [`CPU_ADDR_W-1:0]       pc,
    input  logic                         c_out,
    input  logic                         c_flag,
    alu_if.select                        alu
);

    logic ucode_path;
    logic instr_path;

    // both paths read the second operand the same way
    function automatic logic [`CPU_DATA_W-1:0] pick_src2(
        input cpu_pkg::alu_src2_t      sel,
        input logic [`CPU_DATA_W-1:0] mem
    );
        logic [`CPU_DATA_W-1:0] val;
        val = '0;
        if (sel == cpu_pkg::SRC2_RMEM) begin
            val = mem;
        end
        return val;
    endfunction

    // a microcode add wins over the instruction fields
    assign ucode_path = ucode_vector.alu_op == cpu_pkg::ALUOP_ADD;
    assign instr_path = ucode_vector.alu_op == cpu_pkg::ALUOP_HOLD &&
                        ucode_vector.instr_ctrl == cpu_pkg::INSTR_CTRL_1;

    always_comb begin
        alu.op       = cpu_pkg::ALUOP_HOLD;
        alu.src1     = '0;
        alu.src2     = '0;
        alu.src2_inv = 1'b0;
        alu.c_in     = 1'b0;
        alu.dest     = cpu_pkg::DEST_NONE;
        alu.flags_we = 1'b0;
        if (ucode_path) begin
            // address arithmetic that is never written back
            alu.op       = cpu_pkg::ALUOP_ADD;
            alu.src2_inv = ucode_vector.alu_src2_inv;
            alu.src2     = pick_src2(ucode_vector.alu_src2, r_data);
            case (ucode_vector.alu_src1)
                cpu_pkg::SRC1_X:      alu.src1 = x;
                cpu_pkg::SRC1_Y:      alu.src1 = y;
                cpu_pkg::SRC1_RMEM:   alu.src1 = r_data;
                cpu_pkg::SRC1_SP:     alu.src1 = sp;
                cpu_pkg::SRC1_PCHI:   alu.src1 = pc[`CPU_ADDR_W-1:`CPU_DATA_W];
                cpu_pkg::SRC1_PCLO:   alu.src1 = pc[`CPU_DATA_W-1:0];
                cpu_pkg::SRC1_ALUOUT: alu.src1 = alu_out;
                default:              alu.src1 = '0;
            endcase
            case (ucode_vector.alu_c_src)
                cpu_pkg::ALUC_1:       alu.c_in = 1'b1;
                // chains the carry of the previous byte
                cpu_pkg::ALUC_ALUCOUT: alu.c_in = c_out;
                default:               alu.c_in = 1'b0;
            endcase
        end else if (instr_path) begin
            alu.op       = instr_ctrl_vector.alu_op;
            alu.src2_inv = instr_ctrl_vector.alu_src2_inv;
            alu.src2     = pick_src2(instr_ctrl_vector.alu_src2, r_data);
            case (instr_ctrl_vector.alu_src1)
                cpu_pkg::SRC1_A:    alu.src1 = a;
                cpu_pkg::SRC1_X:    alu.src1 = x;
                cpu_pkg::SRC1_Y:    alu.src1 = y;
                cpu_pkg::SRC1_RMEM: alu.src1 = r_data;
                cpu_pkg::SRC1_SP:   alu.src1 = sp;
                default:            alu.src1 = '0;
            endcase
            case (instr_ctrl_vector.alu_c_src)
                cpu_pkg::ALUC_C: alu.c_in = c_flag;
                cpu_pkg::ALUC_1: alu.c_in = 1'b1;
                default:         alu.c_in = 1'b0;
            endcase
            // a held instruction writes nothing back
            if (instr_ctrl_vector.alu_op != cpu_pkg::ALUOP_HOLD) begin
                alu.dest     = instr_ctrl_vector.alu_dest;
                alu.flags_we = instr_ctrl_vector.alu_flags_we;
            end
        end
    end

    // the microcode add must never reach the register file or the flags
    always_comb begin
        if (ucode_path) begin
            a_ucode_no_wb: assert final (alu.dest == cpu_pkg::DEST_NONE && !alu.flags_we)
                else $error("microcode add issued a write-back");
        end
    end

endmodule : alu_inputs

// ==== logic/alu_if.sv ====
`include "cpu_macros.svh"

interface alu_if;

    // operation and operands from operand selection
    cpu_pkg::ctrl_alu_op_t  op;
    logic [`CPU_DATA_W-1:0] src1;
    logic [`CPU_DATA_W-1:0] src2;
    logic                   src2_inv;
    logic                   c_in;

    // write-back controls
    cpu_pkg::reg_dest_t     dest;
    logic                   flags_we;

    // alu results
    logic [`CPU_DATA_W-1:0] out;
    logic                   c_out;
    logic                   v_out;
    logic                   z_out;
    logic                   n_out;

    modport select (output op, src1, src2, src2_inv, c_in, dest, flags_we);
    modport compute (input op, src1, src2, src2_inv, c_in,
                     output out, c_out, v_out, z_out, n_out);
    modport commit (input op, dest, flags_we, out, c_out, v_out, z_out, n_out);

endinterface : alu_if

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    // alu operations
    typedef enum logic [2:0] {
        ALUOP_HOLD        = 3'd0,
        ALUOP_ADD         = 3'd1,
        ALUOP_AND         = 3'd2,
        ALUOP_OR          = 3'd3,
        ALUOP_XOR         = 3'd4,
        ALUOP_SHIFT_LEFT  = 3'd5,
        ALUOP_SHIFT_RIGHT = 3'd6
    } ctrl_alu_op_t;

    // first operand source
    typedef enum logic [2:0] {
        SRC1_A      = 3'd0,
        SRC1_X      = 3'd1,
        SRC1_Y      = 3'd2,
        SRC1_RMEM   = 3'd3,
        SRC1_SP     = 3'd4,
        SRC1_PCHI   = 3'd5,
        SRC1_PCLO   = 3'd6,
        SRC1_ALUOUT = 3'd7
    } alu_src1_t;

    // second operand source
    typedef enum logic {
        SRC2_RMEM = 1'b0,
        SRC2_0    = 1'b1
    } alu_src2_t;

    // carry-in source
    typedef enum logic [1:0] {
        ALUC_C       = 2'd0,
        ALUC_0       = 2'd1,
        ALUC_1       = 2'd2,
        ALUC_ALUCOUT = 2'd3
    } alu_c_src_t;

    // write-back target
    typedef enum logic [2:0] {
        DEST_NONE = 3'd0,
        DEST_A    = 3'd1,
        DEST_X    = 3'd2,
        DEST_Y    = 3'd3,
        DEST_SP   = 3'd4
    } reg_dest_t;

    // microcode hands the alu to the instruction fields when set
    typedef enum logic {
        INSTR_CTRL_0 = 1'b0,
        INSTR_CTRL_1 = 1'b1
    } instr_ctrl_t;

    // fields decoded from the current instruction, 14 bits
    typedef struct packed {
        ctrl_alu_op_t alu_op;
        alu_src1_t    alu_src1;
        alu_src2_t    alu_src2;
        logic         alu_src2_inv;
        alu_c_src_t   alu_c_src;
        reg_dest_t    alu_dest;
        logic         alu_flags_we;
    } instr_ctrl_signals_t;

    // fields of the current microcode step, 11 bits
    typedef struct packed {
        ctrl_alu_op_t alu_op;
        alu_src1_t    alu_src1;
        alu_src2_t    alu_src2;
        logic         alu_src2_inv;
        alu_c_src_t   alu_c_src;
        instr_ctrl_t  instr_ctrl;
    } ucode_ctrl_signals_t;

    // status bus layout: bit 3 N, bit 2 V, bit 1 Z, bit 0 C
    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } status_t;

endpackage : cpu_pkg

// ==== logic/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath width, one byte
`define CPU_DATA_W 8

// program counter width
`define CPU_ADDR_W 16

// stack pointer after reset, as left by the reset sequence of a 6502
`define CPU_SP_RESET 8'hFD

`endif
